// File: source/viterbi_pkg.sv
`default_nettype none

package viterbi_pkg;

    localparam int NUM_STATES = 4;
    localparam int STATE_W    = 2;
    localparam int SYM_W      = 2;

    // generator taps, 7 and 5 octal, msb is the newest bit
    localparam logic [STATE_W:0] G0 = 3'b111;
    localparam logic [STATE_W:0] G1 = 3'b101;

    localparam int BLOCK_LEN  = 16;  // includes 2 tail bits
    localparam int STEP_W     = 4;
    localparam int PM_W       = 6;

    localparam logic MODE_DECODE = 1'b1;
    localparam int   SETTLE_CYC  = 2;

    typedef enum logic [3:0] {
        IDLE,
        ENCODE,
        LOAD,
        METRIC,
        TRELLIS,
        FLUSH,
        SETTLE,
        TRACE,
        DONE
    } ctl_state_t;

endpackage

`default_nettype wire

// File: source/survivor_if.sv
`default_nettype none

interface survivor_if;

    logic                               wr_en;
    logic [viterbi_pkg::STEP_W-1:0]     wr_addr;
    logic [viterbi_pkg::NUM_STATES-1:0] wr_dec;   // one decision per state

    logic [viterbi_pkg::STEP_W-1:0]     rd_addr;
    logic [viterbi_pkg::NUM_STATES-1:0] rd_dec;   // valid one cycle after rd_addr

    modport writer (
        output wr_en,
        output wr_addr,
        output wr_dec
    );

    modport mem (
        input  wr_en,
        input  wr_addr,
        input  wr_dec,
        input  rd_addr,
        output rd_dec
    );

    modport reader (
        output rd_addr,
        input  rd_dec
    );

endinterface

`default_nettype wire

// File: source/vit_control.sv
`default_nettype none

module vit_control (
    input  logic clk,
    input  logic rst,
    input  logic i_en,
    input  logic i_mode_sel,
    input  logic i_valid,
    input  logic i_last,
    output logic o_en_enc,
    output logic o_en_acs,
    output logic o_en_tb,
    output logic o_done
);

    viterbi_pkg::ctl_state_t state, nxt_state;

    logic [viterbi_pkg::STEP_W:0] step_cnt;  // symbols in TRELLIS, cycles in TRACE
    logic [1:0]                   settle_cnt;

    always_ff @(posedge clk)
    begin
        if (!rst || !i_en)
        begin
            state      <= viterbi_pkg::IDLE;
            step_cnt   <= '0;
            settle_cnt <= '0;
        end
        else
        begin
            state <= nxt_state;
            if (state == viterbi_pkg::TRELLIS)
                step_cnt <= step_cnt + (viterbi_pkg::STEP_W+1)'(i_valid);
            else if (state == viterbi_pkg::TRACE)
                step_cnt <= step_cnt + 1'b1;
            else
                step_cnt <= '0;
            settle_cnt <= (state == viterbi_pkg::SETTLE) ? settle_cnt + 1'b1 : 2'd0;
        end
    end

    always_comb
    begin
        nxt_state = state;
        case (state)
            viterbi_pkg::IDLE:
                nxt_state = (i_mode_sel == viterbi_pkg::MODE_DECODE) ?
                            viterbi_pkg::LOAD : viterbi_pkg::ENCODE;
            viterbi_pkg::ENCODE:
                if (i_mode_sel == viterbi_pkg::MODE_DECODE)
                    nxt_state = viterbi_pkg::IDLE;  // mode change restarts
            viterbi_pkg::LOAD:
                nxt_state = viterbi_pkg::METRIC;
            viterbi_pkg::METRIC:
                nxt_state = viterbi_pkg::TRELLIS;
            viterbi_pkg::TRELLIS:
                if (i_valid && i_last)
                    nxt_state = viterbi_pkg::FLUSH;
            viterbi_pkg::FLUSH:
                nxt_state = viterbi_pkg::SETTLE;
            viterbi_pkg::SETTLE:
                if (settle_cnt == 2'(viterbi_pkg::SETTLE_CYC - 1))
                    nxt_state = viterbi_pkg::TRACE;
            viterbi_pkg::TRACE:
                if (step_cnt == (viterbi_pkg::STEP_W+1)'(viterbi_pkg::BLOCK_LEN + 1))
                    nxt_state = viterbi_pkg::DONE;
            default:
                nxt_state = viterbi_pkg::IDLE;
        endcase
    end

    assign o_en_enc = i_en && (state == viterbi_pkg::ENCODE);
    assign o_en_acs = i_en && (state == viterbi_pkg::TRELLIS || state == viterbi_pkg::FLUSH);
    assign o_en_tb  = i_en && (state == viterbi_pkg::TRACE);
    assign o_done   = i_en && (state == viterbi_pkg::DONE);

    // frame length must agree with the sync marker
    a_last_on_final_step: assert property (@(posedge clk) disable iff (!rst || !i_en)
        (state == viterbi_pkg::TRELLIS && i_valid) |->
        (i_last == (step_cnt == (viterbi_pkg::STEP_W+1)'(viterbi_pkg::BLOCK_LEN - 1))));

    a_no_input_in_trace: assert property (@(posedge clk) disable iff (!rst || !i_en)
        (state == viterbi_pkg::TRACE) |-> !i_valid);

endmodule

`default_nettype wire

// File: source/conv_encoder.sv
`default_nettype none

module conv_encoder (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          i_en_enc,
    input  logic                          i_valid,
    input  logic                          i_bit,
    output logic                          o_valid,
    output logic [viterbi_pkg::SYM_W-1:0] o_sym
);

    logic [viterbi_pkg::STATE_W-1:0] sr;   // two previous bits, newest in msb
    logic [viterbi_pkg::STATE_W:0]   win;

    assign win = {i_bit, sr};

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            sr      <= '0;
            o_valid <= 1'b0;
        end
        else
        begin
            o_valid <= i_en_enc && i_valid;
            if (!i_en_enc)
                sr <= '0;  // next run starts in state 0
            else if (i_valid)
                sr <= {i_bit, sr[viterbi_pkg::STATE_W-1]};
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_en_enc && i_valid)
        begin
            o_sym <= {^(win & viterbi_pkg::G0), ^(win & viterbi_pkg::G1)};
        end
    end

endmodule

`default_nettype wire

// File: source/acs_unit.sv
`default_nettype none

module acs_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          i_en_acs,
    input  logic                          i_valid,
    input  logic [viterbi_pkg::SYM_W-1:0] i_sym,
    survivor_if.writer                    surv
);

    logic [viterbi_pkg::PM_W-1:0]       pm     [viterbi_pkg::NUM_STATES];
    logic [viterbi_pkg::PM_W-1:0]       pm_nxt [viterbi_pkg::NUM_STATES];
    logic [viterbi_pkg::NUM_STATES-1:0] dec;
    logic [viterbi_pkg::STEP_W-1:0]     step;

    // hamming distance between received symbol and branch label
    function automatic logic [viterbi_pkg::PM_W:0] branch_metric(
        input logic [viterbi_pkg::STATE_W:0] win,
        input logic [viterbi_pkg::SYM_W-1:0] sym
    );
        logic [viterbi_pkg::SYM_W-1:0] diff;
        diff = {^(win & viterbi_pkg::G0), ^(win & viterbi_pkg::G1)} ^ sym;
        return (viterbi_pkg::PM_W+1)'(diff[1]) + (viterbi_pkg::PM_W+1)'(diff[0]);
    endfunction

    always_comb
    begin
        for (int i = 0; i < viterbi_pkg::NUM_STATES; i++)
        begin
            logic [viterbi_pkg::STATE_W-1:0] ns;
            logic [viterbi_pkg::PM_W:0]      m0;
            logic [viterbi_pkg::PM_W:0]      m1;
            logic [viterbi_pkg::PM_W:0]      best;
            ns = viterbi_pkg::STATE_W'(i);
            // predecessors are {ns[0], x} and input bit is ns[1]
            m0 = {1'b0, pm[{ns[0], 1'b0}]} + branch_metric({ns, 1'b0}, i_sym);
            m1 = {1'b0, pm[{ns[0], 1'b1}]} + branch_metric({ns, 1'b1}, i_sym);
            dec[i] = (m1 < m0);  // tie keeps lower predecessor
            best   = dec[i] ? m1 : m0;
            if (best > {1'b0, {viterbi_pkg::PM_W{1'b1}}})
                pm_nxt[i] = {viterbi_pkg::PM_W{1'b1}};  // unreachable states stay at max
            else
                pm_nxt[i] = best[viterbi_pkg::PM_W-1:0];
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst || !i_en_acs)
        begin
            step <= '0;
            for (int i = 0; i < viterbi_pkg::NUM_STATES; i++)
                pm[i] <= (i == 0) ? '0 : {viterbi_pkg::PM_W{1'b1}};
        end
        else if (i_valid)
        begin
            step <= step + 1'b1;
            for (int i = 0; i < viterbi_pkg::NUM_STATES; i++)
                pm[i] <= pm_nxt[i];
        end
    end

    assign surv.wr_en   = i_en_acs && i_valid;
    assign surv.wr_addr = step;
    assign surv.wr_dec  = dec;

    // no write may wrap past the last word of a frame
    a_no_step_wrap: assert property (@(posedge clk) disable iff (!rst)
        (surv.wr_en && surv.wr_addr == viterbi_pkg::STEP_W'(viterbi_pkg::BLOCK_LEN - 1))
        |=> !surv.wr_en);

endmodule

`default_nettype wire

// File: source/survivor_mem.sv
`default_nettype none

module survivor_mem (
    input  logic    clk,
    survivor_if.mem surv
);

    logic [viterbi_pkg::NUM_STATES-1:0] mem [viterbi_pkg::BLOCK_LEN];

    always_ff @(posedge clk)
    begin
        if (surv.wr_en)
        begin
            mem[surv.wr_addr] <= surv.wr_dec;
        end
    end

    always_ff @(posedge clk)
    begin
        surv.rd_dec <= mem[surv.rd_addr];  // registered read
    end

endmodule

`default_nettype wire

// File: source/traceback.sv
`default_nettype none

module traceback (
    input  logic        clk,
    input  logic        rst,
    input  logic        i_en_tb,
    survivor_if.reader  surv,
    output logic        o_bit_valid,
    output logic        o_bit
);

    logic [viterbi_pkg::STEP_W-1:0]  addr;
    logic                            issued_all;  // last read address sent
    logic                            rd_vld;      // rd_dec holds a fresh word
    logic [viterbi_pkg::STATE_W-1:0] cur;

    assign surv.rd_addr = addr;

    always_ff @(posedge clk)
    begin
        if (!rst || !i_en_tb)
        begin
            addr        <= viterbi_pkg::STEP_W'(viterbi_pkg::BLOCK_LEN - 1);
            issued_all  <= 1'b0;
            rd_vld      <= 1'b0;
            cur         <= '0;  // frame ends in state 0
            o_bit_valid <= 1'b0;
        end
        else
        begin
            rd_vld <= !issued_all;
            if (!issued_all)
            begin
                addr <= addr - 1'b1;
                if (addr == '0)
                    issued_all <= 1'b1;
            end
            o_bit_valid <= rd_vld;
            if (rd_vld)
                cur <= {cur[0], surv.rd_dec[cur]};  // step back to predecessor
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_vld)
        begin
            o_bit <= cur[viterbi_pkg::STATE_W-1];  // input bit that entered cur
        end
    end

endmodule

`default_nettype wire

// File: source/viterbi_top.sv
`default_nettype none

module viterbi_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          i_en,
    input  logic                          i_mode_sel,
    input  logic                          i_valid,
    input  logic                          i_bit,
    input  logic [viterbi_pkg::SYM_W-1:0] i_sym,
    input  logic                          i_last,
    output logic                          o_sym_valid,
    output logic [viterbi_pkg::SYM_W-1:0] o_sym,
    output logic                          o_bit_valid,
    output logic                          o_bit,
    output logic                          o_done
);

    logic en_enc;
    logic en_acs;
    logic en_tb;

    survivor_if surv ();

    vit_control u_ctl (
        .clk        (clk),
        .rst        (rst),
        .i_en       (i_en),
        .i_mode_sel (i_mode_sel),
        .i_valid    (i_valid),
        .i_last     (i_last),
        .o_en_enc   (en_enc),
        .o_en_acs   (en_acs),
        .o_en_tb    (en_tb),
        .o_done     (o_done)
    );

    conv_encoder u_enc (
        .clk      (clk),
        .rst      (rst),
        .i_en_enc (en_enc),
        .i_valid  (i_valid),
        .i_bit    (i_bit),
        .o_valid  (o_sym_valid),
        .o_sym    (o_sym)
    );

    acs_unit u_acs (
        .clk      (clk),
        .rst      (rst),
        .i_en_acs (en_acs),
        .i_valid  (i_valid),
        .i_sym    (i_sym),
        .surv     (surv)
    );

    survivor_mem u_mem (
        .clk  (clk),
        .surv (surv)
    );

    traceback u_tb (
        .clk         (clk),
        .rst         (rst),
        .i_en_tb     (en_tb),
        .surv        (surv),
        .o_bit_valid (o_bit_valid),
        .o_bit       (o_bit)
    );

endmodule

`default_nettype wire

// File: verif/tb_viterbi.sv
`default_nettype none

module tb_viterbi;

    localparam int CLK_HALF   = 4;
    localparam int DRIVE_DLY  = 1;    // after the rising edge
    localparam int WAIT_LIMIT = 100;  // cycles

    logic                          clk;
    logic                          rst;
    logic                          i_en;
    logic                          i_mode_sel;
    logic                          i_valid;
    logic                          i_bit;
    logic [viterbi_pkg::SYM_W-1:0] i_sym;
    logic                          i_last;
    logic                          o_sym_valid;
    logic [viterbi_pkg::SYM_W-1:0] o_sym;
    logic                          o_bit_valid;
    logic                          o_bit;
    logic                          o_done;

    integer seed;
    int     errors;
    int     checks;

    logic [viterbi_pkg::STATE_W-1:0] model_sr;  // reference encoder history
    logic                            frame_bits [viterbi_pkg::BLOCK_LEN];
    logic [viterbi_pkg::SYM_W-1:0]   frame_syms [viterbi_pkg::BLOCK_LEN];

    viterbi_top dut (
        .clk         (clk),
        .rst         (rst),
        .i_en        (i_en),
        .i_mode_sel  (i_mode_sel),
        .i_valid     (i_valid),
        .i_bit       (i_bit),
        .i_sym       (i_sym),
        .i_last      (i_last),
        .o_sym_valid (o_sym_valid),
        .o_sym       (o_sym),
        .o_bit_valid (o_bit_valid),
        .o_bit       (o_bit),
        .o_done      (o_done)
    );

    initial
    begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    // each output bit is the parity of the new bit and history under one generator
    function automatic logic [viterbi_pkg::SYM_W-1:0] model_encode(input logic b);
        logic [viterbi_pkg::STATE_W:0] taps;
        taps     = {b, model_sr};
        model_sr = {b, model_sr[1]};
        return {^(taps & viterbi_pkg::G0), ^(taps & viterbi_pkg::G1)};
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h at %0t in %s", name, got, exp,
                     $time, dut.u_ctl.state.name());
        end
    endtask

    task automatic wait_for_state(input viterbi_pkg::ctl_state_t target);
        int n;
        n = 0;
        while (dut.u_ctl.state != target && n < WAIT_LIMIT)
        begin
            next_cycle();
            n++;
        end
        if (dut.u_ctl.state != target)
        begin
            errors++;
            $display("timeout: the controller never reached state %s", target.name());
        end
    endtask

    task automatic run_disabled(input int cycles);
        i_en = 1'b0;
        for (int k = 0; k < cycles; k++)
        begin
            i_mode_sel = 1'(next_rand());
            i_valid    = 1'(next_rand());  // strobes must be ignored
            i_bit      = 1'(next_rand());
            i_sym      = 2'(next_rand());
            i_last     = 1'(next_rand());
            next_cycle();
            check_val("o_sym_valid", 32'(o_sym_valid), 32'd0);
            check_val("o_bit_valid", 32'(o_bit_valid), 32'd0);
            check_val("o_done", 32'(o_done), 32'd0);
        end
        i_valid = 1'b0;
        i_last  = 1'b0;
    endtask

    task automatic run_encoder(input int count);
        logic                          b;
        logic [viterbi_pkg::SYM_W-1:0] exp_sym;
        int                            gap;
        model_sr   = '0;
        i_mode_sel = 1'b0;
        i_en       = 1'b1;
        wait_for_state(viterbi_pkg::ENCODE);
        for (int k = 0; k < count; k++)
        begin
            b       = 1'(next_rand());
            exp_sym = model_encode(b);
            i_valid = 1'b1;
            i_bit   = b;
            next_cycle();
            i_valid = 1'b0;
            check_val("o_sym_valid", 32'(o_sym_valid), 32'd1);
            check_val("o_sym", 32'(o_sym), 32'(exp_sym));
            gap = int'(2'(next_rand()));
            repeat (gap)
            begin
                next_cycle();
                check_val("o_sym_valid", 32'(o_sym_valid), 32'd0);
            end
        end
        next_cycle();
        check_val("o_sym_valid", 32'(o_sym_valid), 32'd0);
        i_en = 1'b0;
        next_cycle();
    endtask

    // 14 random data bits then the two zero tail bits
    task automatic build_frame(input logic add_error);
        logic [31:0] r;
        int          pos;
        model_sr = '0;
        for (int k = 0; k < viterbi_pkg::BLOCK_LEN; k++)
        begin
            frame_bits[k] = (k < viterbi_pkg::BLOCK_LEN - 2) ? 1'(next_rand()) : 1'b0;
            frame_syms[k] = model_encode(frame_bits[k]);
        end
        if (add_error)
        begin
            r   = next_rand();
            pos = int'(r[7:0]) % (viterbi_pkg::BLOCK_LEN - 2);
            frame_syms[pos][r[8]] = !frame_syms[pos][r[8]];
        end
    endtask

    task automatic run_decode();
        int gap;
        int n;
        i_mode_sel = 1'b1;
        i_en       = 1'b1;
        wait_for_state(viterbi_pkg::TRELLIS);
        for (int k = 0; k < viterbi_pkg::BLOCK_LEN; k++)
        begin
            i_valid = 1'b1;
            i_sym   = frame_syms[k];
            i_last  = (k == viterbi_pkg::BLOCK_LEN - 1);
            next_cycle();
            i_valid = 1'b0;
            i_last  = 1'b0;
            gap = int'(2'(next_rand()));
            repeat (gap) next_cycle();
        end
        n = 0;
        while (!o_bit_valid && n < WAIT_LIMIT)
        begin
            check_val("o_done", 32'(o_done), 32'd0);
            next_cycle();
            n++;
        end
        if (!o_bit_valid)
        begin
            errors++;
            $display("timeout: no decoded bits came out after the frame");
        end
        n = 0;
        while (o_bit_valid && n < viterbi_pkg::BLOCK_LEN + 4)
        begin
            if (n < viterbi_pkg::BLOCK_LEN)
                check_val("o_bit", 32'(o_bit), 32'(frame_bits[viterbi_pkg::BLOCK_LEN-1-n]));
            check_val("o_done", 32'(o_done), 32'd0);
            n++;
            next_cycle();
        end
        check_val("bit count", 32'(n), 32'(viterbi_pkg::BLOCK_LEN));
        check_val("o_done", 32'(o_done), 32'd1);  // one cycle after last bit
        next_cycle();
        check_val("o_done", 32'(o_done), 32'd0);
        i_en = 1'b0;
        gap = int'(2'(next_rand())) + 2;
        repeat (gap) next_cycle();
    endtask

    initial
    begin
        seed       = 32'hce957633;
        errors     = 0;
        checks     = 0;
        model_sr   = '0;
        rst        = 1'b0;
        i_en       = 1'b0;
        i_mode_sel = 1'b0;
        i_valid    = 1'b0;
        i_bit      = 1'b0;
        i_sym      = '0;
        i_last     = 1'b0;
        repeat (2) next_cycle();
        rst = 1'b1;

        run_disabled(20);
        run_encoder(40);
        build_frame(1'b0);
        run_decode();
        build_frame(1'b1);
        run_decode();
        for (int f = 0; f < 3; f++)
        begin
            build_frame(f == 1);
            run_decode();
        end
        run_disabled(20);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
source/viterbi_pkg.sv
source/survivor_if.sv
source/vit_control.sv
source/conv_encoder.sv
source/acs_unit.sv
source/survivor_mem.sv
source/traceback.sv
source/viterbi_top.sv
verif/tb_viterbi.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_viterbi
FILELIST  := src.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SIM       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
